// ==== source/wh_mem_pkg.sv ====
package wh_mem_pkg;

  // link and header geometry
  localparam int flit_width   = 32;
  localparam int cord_width   = 8;
  localparam int cid_width    = 4;
  localparam int len_width    = 4;
  localparam int ruche_factor = 2;

  // block and memory geometry
  localparam int block_flits        = 4;
  localparam int num_vcaches        = 4;
  localparam int blocks_per_cache   = 16;
  localparam int mem_blocks         = num_vcaches * blocks_per_cache;
  localparam int block_offset_width = 4;

  typedef logic [flit_width-1:0]               flit_t;
  typedef logic [cord_width-1:0]               cord_t;
  typedef logic [cid_width-1:0]                cid_t;
  typedef logic [len_width-1:0]                len_t;
  typedef logic [block_flits*flit_width-1:0]   block_t;
  typedef logic [$clog2(mem_blocks)-1:0]       block_idx_t;
  typedef logic [$clog2(block_flits)-1:0]      flit_count_t;

  // vcache wormhole header, dest_cord in the low bits
  typedef struct packed {
    logic [6:0] unused;
    logic       write_not_read;
    cord_t      src_cord;
    cid_t       cid;
    len_t       len;
    cord_t      dest_cord;
  } wh_header_t;

  typedef struct packed {
    logic  v;
    logic  ready_and_rev;
    flit_t data;
  } wh_link_t;

  typedef enum logic [2:0] {
    reset_s,
    ready_s,
    recv_addr_s,
    recv_evict_s,
    send_fill_header_s,
    send_fill_data_s
  } mem_state_e;

endpackage

// ==== source/wh_mem_ctrl.sv ====
`timescale 1ns/1ps

module wh_mem_ctrl (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  wh_mem_pkg::wh_link_t    link_i,
  output wh_mem_pkg::wh_link_t    link_o,
  input  wh_mem_pkg::flit_t       ser_flit_i,
  input  logic                    ser_v_i,
  output logic                    ser_yumi_o,
  output logic                    des_flit_v_o,
  output logic                    mem_rd_o,
  output logic                    rd_load_o,
  output wh_mem_pkg::block_idx_t  blk_idx_o
);
  import wh_mem_pkg::*;

  mem_state_e  state_r, state_n;
  flit_count_t count_r;
  logic        count_up;
  logic        last_flit;

  logic        write_not_read_r;
  cord_t       src_cord_r;
  cid_t        cid_r;
  flit_t       addr_r;

  logic        take_header;
  logic        take_addr;
  logic        mem_rd_r;
  logic        rd_load_r;

  wh_header_t  header_in;
  wh_header_t  reply_hdr;

  assign header_in = wh_header_t'(link_i.data);

  // reply goes back to the requester
  always_comb begin
    reply_hdr                = '0;
    reply_hdr.dest_cord      = src_cord_r;
    reply_hdr.cid            = cid_r;
    reply_hdr.len            = len_t'(block_flits);
  end

  assign last_flit = (count_r == flit_count_t'(block_flits - 1));

  always_comb begin
    state_n      = state_r;
    link_o       = '0;
    ser_yumi_o   = 1'b0;
    des_flit_v_o = 1'b0;
    take_header  = 1'b0;
    take_addr    = 1'b0;
    count_up     = 1'b0;
    case (state_r)
      reset_s: begin
        state_n = ready_s;
      end
      ready_s: begin
        link_o.ready_and_rev = 1'b1;
        if (link_i.v) begin
          take_header = 1'b1;
          state_n     = recv_addr_s;
        end
      end
      recv_addr_s: begin
        link_o.ready_and_rev = 1'b1;
        if (link_i.v) begin
          take_addr = 1'b1;
          state_n   = write_not_read_r ? recv_evict_s : send_fill_header_s;
        end
      end
      recv_evict_s: begin
        link_o.ready_and_rev = 1'b1;
        des_flit_v_o         = link_i.v;
        if (link_i.v) begin
          count_up = 1'b1;
          if (last_flit) begin
            state_n = ready_s;
          end
        end
      end
      send_fill_header_s: begin
        link_o.v    = 1'b1;
        link_o.data = flit_t'(reply_hdr);
        if (link_i.ready_and_rev) begin
          state_n = send_fill_data_s;
        end
      end
      send_fill_data_s: begin
        link_o.v    = ser_v_i;
        link_o.data = ser_flit_i;
        ser_yumi_o  = ser_v_i & link_i.ready_and_rev;
        if (ser_yumi_o) begin
          count_up = 1'b1;
          if (last_flit) begin
            state_n = ready_s;
          end
        end
      end
      default: begin
        state_n = ready_s;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r          <= reset_s;
      count_r          <= '0;
      write_not_read_r <= 1'b0;
      mem_rd_r         <= 1'b0;
      rd_load_r        <= 1'b0;
    end else begin
      state_r   <= state_n;
      // read one cycle after a fill address, load one cycle after that
      mem_rd_r  <= take_addr & ~write_not_read_r;
      rd_load_r <= mem_rd_r;
      if (count_up) begin
        count_r <= count_r + 1'b1;
      end
      if (take_header) begin
        write_not_read_r <= header_in.write_not_read;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take_header) begin
      src_cord_r <= header_in.src_cord;
      cid_r      <= header_in.cid;
    end
    if (take_addr) begin
      addr_r <= link_i.data;
    end
  end

  // north/south half, then cache column, then block within the cache
  assign blk_idx_o = {
    1'(cid_r / cid_t'(ruche_factor)),
    src_cord_r[0],
    addr_r[block_offset_width +: $clog2(blocks_per_cache)]
  };

  assign mem_rd_o  = mem_rd_r;
  assign rd_load_o = rd_load_r;

endmodule

// ==== source/flit_deserializer.sv ====
`timescale 1ns/1ps

module flit_deserializer (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                flit_v_i,
  input  wh_mem_pkg::flit_t   flit_i,
  output logic                block_v_o,
  output wh_mem_pkg::block_t  block_o
);
  import wh_mem_pkg::*;

  // first flit ends up in shift_r[0]
  flit_t [block_flits-2:0] shift_r;
  flit_count_t             count_r;
  logic                    last_flit;

  assign last_flit = (count_r == flit_count_t'(block_flits - 1));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_r <= '0;
    end else if (flit_v_i) begin
      if (last_flit) begin
        count_r <= '0;
      end else begin
        count_r <= count_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (flit_v_i) begin
      shift_r <= {flit_i, shift_r[block_flits-2:1]};
    end
  end

  // last flit bypasses the shift register
  assign block_o   = {flit_i, shift_r};
  assign block_v_o = flit_v_i & last_flit;

endmodule

// ==== source/flit_serializer.sv ====
`timescale 1ns/1ps

module flit_serializer (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                load_i,
  input  wh_mem_pkg::block_t  block_i,
  input  logic                yumi_i,
  output logic                flit_v_o,
  output wh_mem_pkg::flit_t   flit_o
);
  import wh_mem_pkg::*;

  block_t      block_r;
  flit_count_t pos_r;
  logic        v_r;
  logic        last_flit;

  assign last_flit = (pos_r == flit_count_t'(block_flits - 1));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_r   <= 1'b0;
      pos_r <= '0;
    end else if (load_i) begin
      v_r   <= 1'b1;
      pos_r <= '0;
    end else if (yumi_i & v_r) begin
      pos_r <= pos_r + 1'b1;
      // drop valid once the fourth flit is taken
      if (last_flit) begin
        v_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      block_r <= block_i;
    end
  end

  // lowest flit goes out first
  assign flit_o   = block_r[pos_r*flit_width +: flit_width];
  assign flit_v_o = v_r;

endmodule

// ==== source/block_mem.sv ====
`timescale 1ns/1ps

module block_mem (
  input  logic                    clk_i,
  input  logic                    v_i,
  input  logic                    w_i,
  input  wh_mem_pkg::block_idx_t  idx_i,
  input  wh_mem_pkg::block_t      data_i,
  output wh_mem_pkg::block_t      data_o
);
  import wh_mem_pkg::*;

  block_t mem_r [mem_blocks];
  block_t data_r;

  always_ff @(posedge clk_i) begin
    if (v_i) begin
      if (w_i) begin
        mem_r[idx_i] <= data_i;
      end else begin
        // registered read
        data_r <= mem_r[idx_i];
      end
    end
  end

  assign data_o = data_r;

endmodule

// ==== source/wh_test_mem.sv ====
`timescale 1ns/1ps

module wh_test_mem (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  wh_mem_pkg::wh_link_t  link_i,
  output wh_mem_pkg::wh_link_t  link_o
);
  import wh_mem_pkg::*;

  // serializer side
  flit_t      ser_flit;
  logic       ser_v;
  logic       ser_yumi;
  logic       rd_load;

  // deserializer side
  logic       des_flit_v;
  logic       des_block_v;
  block_t     des_block;

  // memory side
  logic       mem_rd;
  block_idx_t blk_idx;
  block_t     mem_rdata;

  wh_mem_ctrl u_ctrl (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .link_i       (link_i),
    .link_o       (link_o),
    .ser_flit_i   (ser_flit),
    .ser_v_i      (ser_v),
    .ser_yumi_o   (ser_yumi),
    .des_flit_v_o (des_flit_v),
    .mem_rd_o     (mem_rd),
    .rd_load_o    (rd_load),
    .blk_idx_o    (blk_idx)
  );

  flit_deserializer u_des (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .flit_v_i  (des_flit_v),
    .flit_i    (link_i.data),
    .block_v_o (des_block_v),
    .block_o   (des_block)
  );

  // write on a completed block, read on the controller's request
  block_mem u_mem (
    .clk_i  (clk_i),
    .v_i    (des_block_v | mem_rd),
    .w_i    (des_block_v),
    .idx_i  (blk_idx),
    .data_i (des_block),
    .data_o (mem_rdata)
  );

  flit_serializer u_ser (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .load_i   (rd_load),
    .block_i  (mem_rdata),
    .yumi_i   (ser_yumi),
    .flit_v_o (ser_v),
    .flit_o   (ser_flit)
  );

endmodule

// ==== bench/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen #(
  parameter int period_ns    = 20,
  parameter int reset_cycles = 3
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #(period_ns / 2) clk_o = ~clk_o;
  end

  // released just after the last reset edge
  initial begin
    reset_o = 1'b1;
    repeat (reset_cycles) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

// ==== bench/wh_test_mem_asserts.sv ====
`timescale 1ns/1ps

module wh_test_mem_asserts (
  input logic                  clk_i,
  input logic                  reset_i,
  input wh_mem_pkg::wh_link_t  link_i,
  input wh_mem_pkg::wh_link_t  link_o
);

  // outgoing flit held until the downstream takes it
  out_flit_held: assert property (@(posedge clk_i) disable iff (reset_i)
    (link_o.v && !link_i.ready_and_rev) |=> (link_o.v && $stable(link_o.data)))
    else $error("outgoing flit dropped or changed before transfer");

  quiet_in_reset: assert property (@(posedge clk_i) reset_i |-> !link_o.v)
    else $error("outgoing valid high during reset");

endmodule

// ==== bench/wh_test_mem_tb.sv ====
`timescale 1ns/1ps

module wh_test_mem_tb;
  import wh_mem_pkg::*;

  localparam int clk_period    = 20;
  localparam int num_ops       = 13;
  localparam int cycles_per_op = 200;

  typedef logic [$clog2(num_ops)-1:0] op_idx_t;

  typedef struct packed {
    logic  evict;
    cord_t src_cord;
    cid_t  cid;
    flit_t addr;
    logic  stall;
  } op_t;

  logic        clk;
  logic        reset;
  wh_link_t    link_in;
  wh_link_t    link_out;
  op_t         op_table [num_ops];
  flit_t       ref_mem [mem_blocks][block_flits];
  logic        ref_written [mem_blocks];
  logic [31:0] lcg_state;
  int          errors;

  clock_gen #(.period_ns(clk_period), .reset_cycles(3)) u_clk (.clk_o(clk), .reset_o(reset));

  wh_test_mem u_dut (.clk_i(clk), .reset_i(reset), .link_i(link_in), .link_o(link_out));

  bind wh_test_mem wh_test_mem_asserts u_asserts (
    .clk_i(clk_i), .reset_i(reset_i), .link_i(link_i), .link_o(link_o));

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // side of the ruche split, column parity, block within the cache
  function automatic block_idx_t hash_index(cord_t src_cord, cid_t cid, flit_t addr);
    int side;
    int column;
    int row;
    side   = (int'(cid) / ruche_factor) % 2;
    column = int'(src_cord) % 2;
    row    = int'(addr >> 4) % 16;
    return block_idx_t'(side * 32 + column * 16 + row);
  endfunction

  task automatic report_error(string why);
    errors++;
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      report_error($sformatf("FAIL %0t %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_flit(string name, flit_t got, flit_t exp);
    if (got !== exp) begin
      report_error($sformatf("FAIL %0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_header(string name, wh_header_t got, wh_header_t exp);
    if (got !== exp) begin
      report_error($sformatf("FAIL %0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  // returns just after the edge that took the flit
  task automatic send_flit(flit_t data, logic gaps);
    logic        taken;
    logic [31:0] r;
    taken = 1'b0;
    if (gaps) begin
      r = next_rand();
      repeat (r[31:30]) begin
        @(negedge clk);
        link_in.v = 1'b0;
      end
    end
    @(negedge clk);
    link_in.v    = 1'b1;
    link_in.data = data;
    while (!taken) begin
      taken = link_out.ready_and_rev;
      @(posedge clk);
      if (!taken) begin
        @(negedge clk);
      end
    end
  endtask

  task automatic receive_flit(logic stall, output flit_t data);
    logic        taken;
    logic [31:0] r;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      r     = next_rand();
      data  = link_out.data;
      taken = link_out.v & (stall ? r[31] : 1'b1);
      link_in.ready_and_rev = stall ? r[31] : 1'b1;
      @(posedge clk);
    end
  endtask

  task automatic do_evict(op_t op);
    wh_header_t hdr;
    flit_t      data;
    block_idx_t idx;
    hdr                = '0;
    hdr.write_not_read = 1'b1;
    hdr.src_cord       = op.src_cord;
    hdr.cid            = op.cid;
    hdr.len            = len_t'(block_flits + 1);
    idx                = hash_index(op.src_cord, op.cid, op.addr);
    send_flit(hdr, op.stall);
    send_flit(op.addr, op.stall);
    for (int i = 0; i < block_flits; i++) begin
      data = next_rand();
      send_flit(data, op.stall);
      ref_mem[idx][flit_count_t'(i)] = data;
    end
    ref_written[idx] = 1'b1;
    @(negedge clk);
    link_in.v = 1'b0;
    check_bit("link_o.ready_and_rev", link_out.ready_and_rev, 1'b1);
  endtask

  task automatic do_fill(op_t op);
    wh_header_t hdr;
    wh_header_t exp_hdr;
    flit_t      got;
    block_idx_t idx;
    idx = hash_index(op.src_cord, op.cid, op.addr);
    if (!ref_written[idx]) begin
      report_error("fill entry in the table reads a block that was never written");
    end
    hdr           = '0;
    hdr.src_cord  = op.src_cord;
    hdr.cid       = op.cid;
    hdr.len       = len_t'(1);
    exp_hdr           = '0;
    exp_hdr.dest_cord = op.src_cord;
    exp_hdr.cid       = op.cid;
    exp_hdr.len       = len_t'(block_flits);
    send_flit(hdr, 1'b0);
    send_flit(op.addr, 1'b0);
    // reply header due right after the address
    @(negedge clk);
    link_in.v = 1'b0;
    check_bit("link_o.v", link_out.v, 1'b1);
    receive_flit(op.stall, got);
    check_header("link_o.data (reply header)", wh_header_t'(got), exp_hdr);
    for (int i = 0; i < block_flits; i++) begin
      receive_flit(op.stall, got);
      check_flit($sformatf("link_o.data (fill flit %0d)", i), got,
                 ref_mem[idx][flit_count_t'(i)]);
    end
    @(negedge clk);
    link_in.ready_and_rev = 1'b0;
  endtask

  initial begin
    #(clk_period * (cycles_per_op * num_ops + 20));
    $display("timeout: the DUT stopped making progress");
    $display("Done: errors found");
    $fatal(1, "watchdog expired");
  end

  initial begin
    int wait_cycles;
    link_in   = '0;
    lcg_state = 32'h3837_d351;
    errors    = 0;
    for (int i = 0; i < mem_blocks; i++) begin
      ref_written[block_idx_t'(i)] = 1'b0;
    end
    // evict or fill, src_cord, cid, address, stall
    op_table = '{
      '{1'b1, 8'h10, 4'h0, 32'h0000_0120, 1'b0},
      '{1'b0, 8'h10, 4'h0, 32'h0000_0120, 1'b0},
      '{1'b1, 8'h11, 4'h0, 32'h0000_0120, 1'b0},
      '{1'b1, 8'h10, 4'h2, 32'h0000_0120, 1'b0},
      '{1'b0, 8'h10, 4'h0, 32'h0000_0120, 1'b1},
      '{1'b0, 8'h11, 4'h0, 32'h0000_0120, 1'b1},
      '{1'b0, 8'h10, 4'h2, 32'h0000_0120, 1'b1},
      '{1'b0, 8'h12, 4'h1, 32'h0000_012c, 1'b0},
      '{1'b0, 8'h10, 4'h0, 32'habcd_e12f, 1'b1},
      '{1'b1, 8'h23, 4'h3, 32'h0000_03f0, 1'b1},
      '{1'b0, 8'h23, 4'h3, 32'h0000_03f0, 1'b1},
      '{1'b1, 8'h10, 4'h0, 32'h0000_0120, 1'b0},
      '{1'b0, 8'h10, 4'h0, 32'h0000_0120, 1'b1}
    };
    do begin
      @(negedge clk);
      check_bit("link_o.v", link_out.v, 1'b0);
      check_bit("link_o.ready_and_rev", link_out.ready_and_rev, 1'b0);
    end while (reset);
    wait_cycles = 0;
    while (!link_out.ready_and_rev && wait_cycles < 4) begin
      @(negedge clk);
      wait_cycles++;
    end
    check_bit("link_o.ready_and_rev", link_out.ready_and_rev, 1'b1);
    check_bit("link_o.v", link_out.v, 1'b0);
    for (int k = 0; k < num_ops; k++) begin
      if (op_table[op_idx_t'(k)].evict) begin
        do_evict(op_table[op_idx_t'(k)]);
      end else begin
        do_fill(op_table[op_idx_t'(k)]);
      end
    end
    if (errors == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      $display("Done: errors found");
      $fatal(1, "errors were counted");
    end
  end

endmodule

// ==== wh_test_mem.f ====
source/wh_mem_pkg.sv
source/wh_mem_ctrl.sv
source/flit_deserializer.sv
source/flit_serializer.sv
source/block_mem.sv
source/wh_test_mem.sv
bench/clock_gen.sv
bench/wh_test_mem_asserts.sv
bench/wh_test_mem_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the wormhole test memory simulation
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f wh_test_mem.f \
  --top-module wh_test_mem_tb \
  -o wh_test_mem_sim

./obj_dir/wh_test_mem_sim
